// ==== Makefile ====
TOP := tb_spikformer_linear_lif

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o Vtb
	./obj_dir/Vtb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Test failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== dv/spk_checker.sv ====
// Watches the DUT ports only; beats seen while reset is low are dropped with their token
`default_nettype none

`include "spk_defs.svh"

module spk_checker (
    input  wire logic                s_clk,
    input  wire logic                i_rst_n,
    input  wire logic                i_beat_valid,
    input  wire spk_pkg::in_beat_t   i_beat,
    input  wire logic                i_psum_valid,
    input  wire spk_pkg::psum_vec_t  i_psum,
    input  wire logic                i_spikes_valid,
    input  wire spk_pkg::spike_vec_t i_spikes,
    output int                       o_err_count,
    output int                       o_pending
);

    timeunit 1ns;
    timeprecision 1ps;

    import spk_pkg::*;

    in_beat_t   beats[$];        // Current token so far
    psum_vec_t  exp_psum_q[$];
    spike_vec_t exp_spk_q[$];
    int         psum_due_q[$];   // Cycle in which each result must show
    int         spk_due_q[$];
    int         cyc = 0;
    int         err_count = 0;
    int         pending = 0;

    assign o_err_count = err_count;
    assign o_pending   = pending;

    // Sum of the weights whose spike is set, per unit and time step
    function automatic psum_vec_t ref_psums(input in_beat_t tok[$]);
        psum_vec_t r;
        weight_t   w;
        int        acc;
        for (int u = 0; u < `SPK_UNITS; u++) begin
            for (int t = 0; t < `SPK_TIME_STEPS; t++) begin
                acc = 0;
                foreach (tok[i]) begin
                    w = tok[i].weights[u];
                    if (tok[i].spikes[t]) acc += int'(w);
                end
                r.sum[u][t] = psum_t'(acc);
            end
        end
        return r;
    endfunction

    function automatic spike_vec_t ref_spikes(input psum_vec_t p);
        spike_vec_t r;
        psum_t      x;
        int         mem;
        int         v;
        r = '0;
        for (int u = 0; u < `SPK_UNITS; u++) begin
            mem = 0;
            for (int t = 0; t < `SPK_TIME_STEPS; t++) begin
                x = p.sum[u][t];
                v = mem + ((int'(x) - mem) >>> 1);   // Halfway to the input, rounded down
                r.spk[u][t] = (v >= `SPK_LIF_THRESHOLD);
                mem = r.spk[u][t] ? 0 : v;
            end
        end
        return r;
    endfunction

    task automatic check_psum();
        psum_vec_t e;
        psum_t     pe;
        psum_t     pa;
        int        due;
        if (exp_psum_q.size() == 0) begin
            $display("o_psum_valid pulsed at %0t with no token pending", $time);
            err_count++;
            return;
        end
        e   = exp_psum_q.pop_front();
        due = psum_due_q.pop_front();
        if (cyc != due) begin
            $display("o_psum_valid at %0t is %0d cycles off its slot", $time, cyc - due);
            err_count++;
        end
        for (int u = 0; u < `SPK_UNITS; u++) begin
            for (int t = 0; t < `SPK_TIME_STEPS; t++) begin
                pe = e.sum[u][t];
                pa = i_psum.sum[u][t];
                if (pe !== pa) begin
                    $display("error at %0t: o_psum.sum[%0d][%0d] expected %0d, got %0d",
                             $time, u, t, pe, pa);
                    err_count++;
                end
            end
        end
    endtask

    task automatic check_spikes();
        spike_vec_t e;
        int         due;
        if (exp_spk_q.size() == 0) begin
            $display("o_spikes_valid pulsed at %0t with no token pending", $time);
            err_count++;
            return;
        end
        e   = exp_spk_q.pop_front();
        due = spk_due_q.pop_front();
        pending--;
        if (cyc != due) begin
            $display("o_spikes_valid at %0t is %0d cycles off its slot", $time, cyc - due);
            err_count++;
        end
        for (int u = 0; u < `SPK_UNITS; u++) begin
            if (e.spk[u] !== i_spikes.spk[u]) begin
                $display("error at %0t: o_spikes.spk[%0d] expected %b, got %b",
                         $time, u, e.spk[u], i_spikes.spk[u]);
                err_count++;
            end
        end
    endtask

    // Outputs are read before the DUT registers update on this edge
    always @(posedge s_clk) begin : watch
        psum_vec_t e;
        cyc++;
        if (!i_rst_n) begin
            if (pending != 0) begin
                $display("reset at %0t dropped %0d tokens before their output", $time, pending);
                err_count++;
            end
            beats.delete();
            exp_psum_q.delete();
            exp_spk_q.delete();
            psum_due_q.delete();
            spk_due_q.delete();
            pending = 0;
        end else begin
            if (i_psum_valid) check_psum();
            if (i_spikes_valid) check_spikes();
            if (i_beat_valid) begin
                beats.push_back(i_beat);
                if (i_beat.last) begin
                    e = ref_psums(beats);
                    exp_psum_q.push_back(e);
                    exp_spk_q.push_back(ref_spikes(e));
                    psum_due_q.push_back(cyc + 2);
                    spk_due_q.push_back(cyc + 3);
                    beats.delete();
                    pending++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_spikformer_linear_lif.sv ====
// One clock, inputs change on falling edges; all result checks are done in spk_checker
`default_nettype none

`include "spk_defs.svh"

module tb_spikformer_linear_lif;

    timeunit 1ns;
    timeprecision 1ps;

    import spk_pkg::*;

    localparam int N_TESTS         = 5;
    localparam int N_RANDOM_TOKENS = 20;

    logic       s_clk;
    logic       i_rst_n;
    logic       i_beat_valid;
    in_beat_t   i_beat;
    logic       o_psum_valid;
    psum_vec_t  o_psum;
    logic       o_spikes_valid;
    spike_vec_t o_spikes;
    int         err_count;
    int         pending;       // Tokens closed but not yet seen at the spike output

    int cycle_cnt   = 0;
    int cycle_limit = 0;
    int tests_ok    = 0;
    int tests_bad   = 0;
    int rand_len[N_RANDOM_TOKENS];

    spikformer_linear_lif u_spikformer_linear_lif (
        .s_clk          ( s_clk          ),
        .i_rst_n        ( i_rst_n        ),
        .i_beat_valid   ( i_beat_valid   ),
        .i_beat         ( i_beat         ),
        .o_psum_valid   ( o_psum_valid   ),
        .o_psum         ( o_psum         ),
        .o_spikes_valid ( o_spikes_valid ),
        .o_spikes       ( o_spikes       )
    );

    spk_checker u_spk_checker (
        .s_clk          ( s_clk          ),
        .i_rst_n        ( i_rst_n        ),
        .i_beat_valid   ( i_beat_valid   ),
        .i_beat         ( i_beat         ),
        .i_psum_valid   ( o_psum_valid   ),
        .i_psum         ( o_psum         ),
        .i_spikes_valid ( o_spikes_valid ),
        .i_spikes       ( o_spikes       ),
        .o_err_count    ( err_count      ),
        .o_pending      ( pending        )
    );

    initial begin
        s_clk = 1'b0;
        forever #10 s_clk = ~s_clk;
    end

    always @(posedge s_clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles, %0d tokens still waiting", cycle_limit, pending);
            $display("Test failed");
            $finish;
        end
    end

    // Mode 0 silent spikes, 1 random, 2 dense spikes with large positive weights
    function automatic in_beat_t make_beat(input int mode, input logic last);
        in_beat_t b;
        b.last = last;
        case (mode)
            0:       b.spikes = '0;
            2:       b.spikes = '1;
            default: b.spikes = `SPK_TIME_STEPS'($urandom);
        endcase
        for (int u = 0; u < `SPK_UNITS; u++) begin
            b.weights[u] = (mode == 2) ? weight_t'($urandom_range(127, 64)) : weight_t'($urandom);
        end
        return b;
    endfunction

    task automatic send_beat(input in_beat_t b);
        @(negedge s_clk);
        i_beat_valid = 1'b1;
        i_beat       = b;
    endtask

    task automatic send_token(input int n_beats, input int mode);
        for (int i = 0; i < n_beats; i++) begin
            send_beat(make_beat(mode, i == n_beats - 1));
        end
    endtask

    // Idle the input and wait until every closed token has left the pipeline
    task automatic drain();
        @(negedge s_clk);
        i_beat_valid = 1'b0;
        while (pending != 0) @(negedge s_clk);
    endtask

    task automatic close_test(input int num, input string name, input int err_before);
        int n_err;
        n_err = err_count - err_before;
        if (n_err == 0) begin
            tests_ok++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", num, name, n_err);
        end
    endtask

    initial begin
        int       total_beats;
        int       err_mark;
        in_beat_t b;
        i_rst_n      = 1'b0;
        i_beat_valid = 1'b0;
        i_beat       = '0;
        void'($urandom(66074));
        total_beats = 8 + 1 + 9 + 5 + 3;   // Directed tests
        foreach (rand_len[k]) begin
            rand_len[k] = 1 + $urandom_range(15, 0);
            total_beats += rand_len[k];
        end
        cycle_limit = total_beats + 20 * N_TESTS;
        repeat (4) @(negedge s_clk);
        i_rst_n = 1'b1;

        err_mark = err_count;
        send_token(8, 0);
        drain();
        close_test(1, "silent spikes", err_mark);

        err_mark = err_count;
        b.spikes     = '1;
        b.weights[0] = weight_t'(127);
        b.weights[1] = weight_t'(64);
        b.weights[2] = weight_t'(-128);
        b.weights[3] = weight_t'(0);
        b.last       = 1'b1;
        send_beat(b);
        drain();
        close_test(2, "single beat, edge weights", err_mark);

        err_mark = err_count;
        foreach (rand_len[k]) send_token(rand_len[k], 1);
        drain();
        close_test(3, "random tokens back to back", err_mark);

        // Sums between 128 and 381 fire on some steps and rest on others
        err_mark = err_count;
        send_token(2, 2);
        send_token(2, 2);
        send_token(3, 2);
        send_token(2, 2);
        drain();
        close_test(4, "dense firing", err_mark);

        err_mark = err_count;
        for (int i = 0; i < 5; i++) send_beat(make_beat(1, 1'b0));
        @(negedge s_clk);
        i_beat_valid = 1'b0;
        i_rst_n      = 1'b0;
        repeat (4) @(negedge s_clk);
        i_rst_n = 1'b1;
        send_token(3, 1);
        drain();
        close_test(5, "reset inside a token", err_mark);

        $display("summary: %0d tests, %0d ok, %0d with errors, %0d errors in total",
                 N_TESTS, tests_ok, tests_bad, err_count);
        if (tests_bad == 0 && err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/lif_group.sv ====
// All time steps of all units are solved in one cycle; membrane starts at zero for every token
`default_nettype none

`include "spk_defs.svh"

module lif_group (
    input  wire logic               s_clk,
    input  wire logic               i_rst_n,
    input  wire logic               i_psum_valid,
    input  wire spk_pkg::psum_vec_t i_psum,
    output logic                    o_spikes_valid,
    output spk_pkg::spike_vec_t     o_spikes
);

    import spk_pkg::*;

    // One extra bit so the difference term cannot wrap
    localparam int MEM_W = `SPK_PSUM_WIDTH + 1;

    spike_vec_t spk_next;

    // Leaky integrate with a decay of one half, hard reset on fire
    always_comb begin : lif_eval
        logic signed [MEM_W-1:0] mem;
        logic signed [MEM_W-1:0] diff;
        logic signed [MEM_W-1:0] nxt;
        spk_next = '0;
        for (int u = 0; u < `SPK_UNITS; u++) begin
            mem = '0;
            for (int t = 0; t < `SPK_TIME_STEPS; t++) begin
                diff = MEM_W'(i_psum.sum[u][t]) - mem;
                nxt  = mem + (diff >>> 1);   // Floor of the half
                spk_next.spk[u][t] = (nxt >= `SPK_LIF_THRESHOLD);
                mem = spk_next.spk[u][t] ? '0 : nxt;
            end
        end
    end

    always_ff @(posedge s_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_spikes_valid <= 1'b0;
        end else begin
            o_spikes_valid <= i_psum_valid;
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_psum_valid) begin
            o_spikes <= spk_next;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/psum_accumulator.sv ====
// Tokens longer than SPK_MAX_FEATURES beats are not supported; sums are held until the next token
`default_nettype none

`include "spk_defs.svh"

module psum_accumulator (
    input  wire logic             s_clk,
    input  wire logic             i_rst_n,
    input  wire logic             i_add_valid,
    input  wire spk_pkg::addend_t i_add,
    output logic                  o_psum_valid,
    output spk_pkg::psum_vec_t    o_psum
);

    import spk_pkg::*;

    localparam int CNT_W = $clog2(`SPK_MAX_FEATURES + 1);

    logic             r_fresh;      // Next addend opens a new token
    logic [CNT_W-1:0] r_feat_cnt;   // Beats seen in the current token
    psum_vec_t        sum_next;

    // o_psum doubles as the running sum, so a finished token stays
    // visible during its valid pulse before the next one overwrites it
    always_comb begin
        psum_t base;
        for (int u = 0; u < `SPK_UNITS; u++) begin
            for (int t = 0; t < `SPK_TIME_STEPS; t++) begin
                base = r_fresh ? psum_t'(0) : o_psum.sum[u][t];
                sum_next.sum[u][t] = base + psum_t'(i_add.add[u][t]);
            end
        end
    end

    always_ff @(posedge s_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_fresh      <= 1'b1;
            r_feat_cnt   <= '0;
            o_psum_valid <= 1'b0;
        end else begin
            o_psum_valid <= i_add_valid && i_add.last;
            if (i_add_valid) begin
                r_fresh    <= i_add.last;
                r_feat_cnt <= r_fresh ? CNT_W'(1) : r_feat_cnt + CNT_W'(1);
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_add_valid) begin
            o_psum <= sum_next;
        end
    end

    // Beyond this length the partial sums may overflow
    a_token_length: assert property (
        @(posedge s_clk) disable iff (!i_rst_n)
        r_feat_cnt <= CNT_W'(`SPK_MAX_FEATURES)
    ) else $error("psum_accumulator: token longer than %0d beats", `SPK_MAX_FEATURES);

endmodule

`default_nettype wire

// ==== hdl/spike_weight_gate.sv ====
// One register stage; accepts a beat on every cycle with no back-pressure
`default_nettype none

`include "spk_defs.svh"

module spike_weight_gate (
    input  wire logic              s_clk,
    input  wire logic              i_rst_n,
    input  wire logic              i_beat_valid,
    input  wire spk_pkg::in_beat_t i_beat,
    output logic                   o_add_valid,
    output spk_pkg::addend_t       o_add
);

    import spk_pkg::*;

    addend_t add_next;

    // Binary spikes turn the multiply into a select
    always_comb begin
        add_next.last = i_beat.last;
        for (int u = 0; u < `SPK_UNITS; u++) begin
            for (int t = 0; t < `SPK_TIME_STEPS; t++) begin
                add_next.add[u][t] = i_beat.spikes[t] ? i_beat.weights[u] : weight_t'(0);
            end
        end
    end

    always_ff @(posedge s_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_add_valid <= 1'b0;
        end else begin
            o_add_valid <= i_beat_valid;
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_beat_valid) begin
            o_add <= add_next;
        end
    end

    // Stimulus must be fully defined whenever it is offered
    a_beat_known: assert property (
        @(posedge s_clk) disable iff (!i_rst_n)
        i_beat_valid |-> !$isunknown(i_beat)
    ) else $error("spike_weight_gate: beat has unknown bits while valid");

endmodule

`default_nettype wire

// ==== hdl/spikformer_linear_lif.sv ====
// Three-stage pipeline, no back-pressure; psums 2 and spikes 3 cycles after a last beat
`default_nettype none

module spikformer_linear_lif (
    input  wire logic               s_clk,
    input  wire logic               i_rst_n,
    input  wire logic               i_beat_valid,
    input  wire spk_pkg::in_beat_t  i_beat,
    output logic                    o_psum_valid,
    output spk_pkg::psum_vec_t      o_psum,
    output logic                    o_spikes_valid,
    output spk_pkg::spike_vec_t     o_spikes
);

    import spk_pkg::*;

    logic    w_add_valid;
    addend_t w_add;

    spike_weight_gate u_spike_weight_gate (
        .s_clk          ( s_clk          ),
        .i_rst_n        ( i_rst_n        ),
        .i_beat_valid   ( i_beat_valid   ),
        .i_beat         ( i_beat         ),
        .o_add_valid    ( w_add_valid    ),
        .o_add          ( w_add          )
    );

    psum_accumulator u_psum_accumulator (
        .s_clk          ( s_clk          ),
        .i_rst_n        ( i_rst_n        ),
        .i_add_valid    ( w_add_valid    ),
        .i_add          ( w_add          ),
        .o_psum_valid   ( o_psum_valid   ),
        .o_psum         ( o_psum         )
    );

    // Partial sums also leave the top for inspection
    lif_group u_lif_group (
        .s_clk          ( s_clk          ),
        .i_rst_n        ( i_rst_n        ),
        .i_psum_valid   ( o_psum_valid   ),
        .i_psum         ( o_psum         ),
        .o_spikes_valid ( o_spikes_valid ),
        .o_spikes       ( o_spikes       )
    );

endmodule

`default_nettype wire

// ==== hdl/spk_pkg.sv ====
// Field order fixes the bit layout of every link; unit index is outer, time step is inner
`default_nettype none

`include "spk_defs.svh"

package spk_pkg;

    typedef logic signed [`SPK_W_WIDTH-1:0]    weight_t;
    typedef logic signed [`SPK_PSUM_WIDTH-1:0] psum_t;

    // One input feature of a token
    typedef struct packed {
        logic [`SPK_TIME_STEPS-1:0] spikes;   // Bit t is the spike at time step t
        weight_t [`SPK_UNITS-1:0]   weights;  // One weight per output unit
        logic                       last;     // Closes the token
    } in_beat_t;

    // Weights after gating by the spikes
    typedef struct packed {
        weight_t [`SPK_UNITS-1:0][`SPK_TIME_STEPS-1:0] add;
        logic                                          last;
    } addend_t;

    // Token result per unit and time step
    typedef struct packed {
        psum_t [`SPK_UNITS-1:0][`SPK_TIME_STEPS-1:0] sum;
    } psum_vec_t;

    typedef struct packed {
        logic [`SPK_UNITS-1:0][`SPK_TIME_STEPS-1:0] spk;
    } spike_vec_t;

endpackage

`default_nettype wire

// ==== include/spk_defs.svh ====
// Sizes are fixed at compile time; SPK_PSUM_WIDTH must hold SPK_MAX_FEATURES full-scale weights
`ifndef SPK_DEFS_SVH
`define SPK_DEFS_SVH

// Array shape
`define SPK_UNITS          4     // Output units per beat
`define SPK_TIME_STEPS     4

// Data widths, both signed
`define SPK_W_WIDTH        8
`define SPK_PSUM_WIDTH     20

// LIF neuron
`define SPK_LIF_THRESHOLD  128   // Fires when the membrane reaches this value

// Longest token in beats. 1024 x -128 still fits in SPK_PSUM_WIDTH
`define SPK_MAX_FEATURES   1024

`endif

// ==== sim.f ====
+incdir+include
hdl/spk_pkg.sv
hdl/spike_weight_gate.sv
hdl/psum_accumulator.sv
hdl/lif_group.sv
hdl/spikformer_linear_lif.sv
dv/spk_checker.sv
dv/tb_spikformer_linear_lif.sv
